// File: bench/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input wire                           clk,
    input wire                           latency_counter_reset,
    input wire                           ch0_cmd_valid,
    input wire                           ch0_cmd_ready,
    input wire                           ch0_cmd_we,
    input wire acp_mem_pkg::addr_t       ch0_cmd_addr,
    input wire acp_mem_pkg::burst_code_t ch0_cmd_burst,
    input wire                           ch0_wdata_valid,
    input wire acp_mem_pkg::word_t       ch0_wdata,
    input wire                           ch0_rdata_valid,
    input wire acp_mem_pkg::word_t       ch0_rdata,
    input wire                           ch0_done,
    input wire                           ch1_cmd_valid,
    input wire                           ch1_cmd_ready,
    input wire                           ch1_cmd_we,
    input wire acp_mem_pkg::addr_t       ch1_cmd_addr,
    input wire acp_mem_pkg::burst_code_t ch1_cmd_burst,
    input wire                           ch1_wdata_valid,
    input wire acp_mem_pkg::word_t       ch1_wdata,
    input wire                           ch1_rdata_valid,
    input wire acp_mem_pkg::word_t       ch1_rdata,
    input wire                           ch1_done
);

    localparam int READ_DATA = 0;
    localparam int BURST_LEN = 1;
    localparam int WRAP = 2;
    localparam int ISOLATION = 3;
    localparam int READY = 4;
    localparam int CONTENTION = 5;
    localparam int NUM_TESTS = 6;

    // Shadow copy of the sample RAM
    acp_mem_pkg::word_t shadow [acp_mem_pkg::DEPTH];

    // Outstanding command per channel
    logic busy [2];
    logic is_write [2];
    acp_mem_pkg::addr_t start [2];
    int beats [2];
    int beat_idx [2];
    int load_cnt [2];
    acp_mem_pkg::word_t load_buf [2][acp_mem_pkg::MAX_BURST];
    logic ready_due [2];
    int streak [2];
    int accepted [2];
    int completed [2];

    int checks [NUM_TESTS];
    int errors [NUM_TESTS];

    function automatic string test_name(input int t);
        case (t)
            READ_DATA: return "read_data";
            BURST_LEN: return "burst_length";
            WRAP: return "wrap_around";
            ISOLATION: return "isolation";
            READY: return "ready_reset";
            default: return "contention";
        endcase
    endfunction

    task automatic compare_value(input int t, input int ch, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("Fail %s: channel %0d %s, expected %h, actual %h",
                     test_name(t), ch, what, exp, act);
        end
    endtask

    task automatic expect_true(input int t, input logic cond, input string msg);
        checks[t]++;
        if (cond !== 1'b1) begin
            errors[t]++;
            $display("Error %s: %s", test_name(t), msg);
        end
    endtask

    task automatic watch_channel(
        input int                       ch,
        input logic                     cmd_valid,
        input logic                     cmd_ready,
        input logic                     cmd_we,
        input acp_mem_pkg::addr_t       cmd_addr,
        input acp_mem_pkg::burst_code_t cmd_burst,
        input logic                     wdata_valid,
        input acp_mem_pkg::word_t       wdata,
        input logic                     rdata_valid,
        input acp_mem_pkg::word_t       rdata,
        input logic                     done
    );
        int other;
        int a;
        int t;
        logic waiting;
        other = 1 - ch;
        if (latency_counter_reset) begin
            expect_true(READY, !done && !rdata_valid,
                $sformatf("channel %0d gave done or rdata_valid during reset", ch));
            busy[ch] = 1'b0;
            ready_due[ch] = 1'b1;
            streak[ch] = 0;
        end else begin
            // Ready must be up right after reset and after done
            if (ready_due[ch]) begin
                expect_true(READY, cmd_ready,
                    $sformatf("channel %0d cmd_ready low when the channel should be idle", ch));
                ready_due[ch] = 1'b0;
            end else if (busy[ch]) begin
                expect_true(READY, !cmd_ready,
                    $sformatf("channel %0d cmd_ready high with a command outstanding", ch));
            end

            if (rdata_valid) begin
                expect_true(ISOLATION, busy[ch],
                    $sformatf("channel %0d returned a read word with no command", ch));
                if (busy[ch]) begin
                    expect_true(BURST_LEN, !is_write[ch] && beat_idx[ch] < beats[ch],
                        $sformatf("channel %0d returned a read word outside its read burst", ch));
                    if (!is_write[ch] && beat_idx[ch] < beats[ch]) begin
                        a = (start[ch] + beat_idx[ch]) % acp_mem_pkg::DEPTH;
                        t = (start[ch] + beats[ch] > acp_mem_pkg::DEPTH) ? WRAP : READ_DATA;
                        compare_value(t, ch, $sformatf("word %0d at address %0d", beat_idx[ch], a),
                            shadow[a], rdata);
                        beat_idx[ch]++;
                    end
                end
            end

            if (wdata_valid && busy[ch] && is_write[ch] && load_cnt[ch] < beats[ch]) begin
                load_buf[ch][load_cnt[ch]] = wdata;
                load_cnt[ch]++;
            end

            if (done) begin
                expect_true(ISOLATION, busy[ch],
                    $sformatf("channel %0d pulsed done with no command", ch));
                if (busy[ch]) begin
                    if (is_write[ch]) begin
                        for (int i = 0; i < beats[ch]; i++) begin
                            shadow[(start[ch] + i) % acp_mem_pkg::DEPTH] = load_buf[ch][i];
                        end
                    end else begin
                        compare_value(BURST_LEN, ch, "read beat count", beats[ch], beat_idx[ch]);
                    end
                    // Bursts in a row while the other channel sits on the bus request
                    waiting = busy[other] && (!is_write[other] || load_cnt[other] == beats[other]);
                    if (waiting) begin
                        streak[ch]++;
                    end else begin
                        streak[ch] = 0;
                    end
                    streak[other] = 0;
                    expect_true(CONTENTION, streak[ch] <= 2,
                        $sformatf("channel %0d completed three bursts while the other waited", ch));
                    busy[ch] = 1'b0;
                    completed[ch]++;
                    ready_due[ch] = 1'b1;
                end
            end

            if (cmd_valid && cmd_ready) begin
                busy[ch] = 1'b1;
                is_write[ch] = cmd_we;
                start[ch] = cmd_addr;
                beats[ch] = 1 << cmd_burst;
                beat_idx[ch] = 0;
                load_cnt[ch] = 0;
                accepted[ch]++;
            end
        end
    endtask

    // Mid-cycle sampling, all lines settled
    always @(negedge clk) begin
        watch_channel(0, ch0_cmd_valid, ch0_cmd_ready, ch0_cmd_we, ch0_cmd_addr, ch0_cmd_burst,
            ch0_wdata_valid, ch0_wdata, ch0_rdata_valid, ch0_rdata, ch0_done);
        watch_channel(1, ch1_cmd_valid, ch1_cmd_ready, ch1_cmd_we, ch1_cmd_addr, ch1_cmd_burst,
            ch1_wdata_valid, ch1_wdata, ch1_rdata_valid, ch1_rdata, ch1_done);
    end

    task report_tests(output int n_pass, output int n_fail);
        for (int ch = 0; ch < 2; ch++) begin
            expect_true(ISOLATION, !busy[ch] && accepted[ch] == completed[ch],
                $sformatf("channel %0d has a command that never finished", ch));
        end
        expect_true(CONTENTION, completed[0] > 0 && completed[1] > 0,
            "a channel completed no burst at all");
        expect_true(WRAP, checks[WRAP] > 0, "no read burst wrapped past address 31");
        n_pass = 0;
        n_fail = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("Test %s: %0d checks, %0d errors, %s", test_name(t), checks[t], errors[t],
                     (errors[t] == 0) ? "ok" : "failed");
            if (errors[t] == 0) begin
                n_pass++;
            end else begin
                n_fail++;
            end
        end
    endtask

endmodule

`default_nettype wire

// File: bench/tb_acp_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acp_mem;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int FILL_CMDS = acp_mem_pkg::DEPTH / acp_mem_pkg::MAX_BURST;
    localparam int WRAP_CMDS = 5;
    localparam int RANDOM_CMDS = 60;
    localparam int TOTAL_CMDS = 2 * (FILL_CMDS + WRAP_CMDS + RANDOM_CMDS);

    // Worst case per command, doubled for the other channel's share of the bus
    localparam longint WATCHDOG_CYCLES =
        TOTAL_CMDS * (acp_mem_pkg::LATENCY + 8 + 12) * 2 + RESET_CYCLES;

    logic clk;
    logic latency_counter_reset;

    logic cmd_valid [2];
    logic cmd_we [2];
    acp_mem_pkg::addr_t cmd_addr [2];
    acp_mem_pkg::burst_code_t cmd_burst [2];
    logic wdata_valid [2];
    acp_mem_pkg::word_t wdata [2];

    wire [1:0] cmd_ready;
    wire [1:0] rdata_valid;
    wire [1:0] done;
    acp_mem_pkg::word_t ch0_rdata;
    acp_mem_pkg::word_t ch1_rdata;

    acp_mem_subsystem uut (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .ch0_cmd_valid(cmd_valid[0]), .ch0_cmd_ready(cmd_ready[0]),
        .ch0_cmd_we(cmd_we[0]), .ch0_cmd_addr(cmd_addr[0]), .ch0_cmd_burst(cmd_burst[0]),
        .ch0_wdata_valid(wdata_valid[0]), .ch0_wdata(wdata[0]),
        .ch0_rdata_valid(rdata_valid[0]), .ch0_rdata(ch0_rdata), .ch0_done(done[0]),
        .ch1_cmd_valid(cmd_valid[1]), .ch1_cmd_ready(cmd_ready[1]),
        .ch1_cmd_we(cmd_we[1]), .ch1_cmd_addr(cmd_addr[1]), .ch1_cmd_burst(cmd_burst[1]),
        .ch1_wdata_valid(wdata_valid[1]), .ch1_wdata(wdata[1]),
        .ch1_rdata_valid(rdata_valid[1]), .ch1_rdata(ch1_rdata), .ch1_done(done[1])
    );

    mem_checker chk (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .ch0_cmd_valid(cmd_valid[0]), .ch0_cmd_ready(cmd_ready[0]),
        .ch0_cmd_we(cmd_we[0]), .ch0_cmd_addr(cmd_addr[0]), .ch0_cmd_burst(cmd_burst[0]),
        .ch0_wdata_valid(wdata_valid[0]), .ch0_wdata(wdata[0]),
        .ch0_rdata_valid(rdata_valid[0]), .ch0_rdata(ch0_rdata), .ch0_done(done[0]),
        .ch1_cmd_valid(cmd_valid[1]), .ch1_cmd_ready(cmd_ready[1]),
        .ch1_cmd_we(cmd_we[1]), .ch1_cmd_addr(cmd_addr[1]), .ch1_cmd_burst(cmd_burst[1]),
        .ch1_wdata_valid(wdata_valid[1]), .ch1_wdata(wdata[1]),
        .ch1_rdata_valid(rdata_valid[1]), .ch1_rdata(ch1_rdata), .ch1_done(done[1])
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One command from acceptance to its done pulse
    task automatic issue_command(input int ch, input logic we, input acp_mem_pkg::addr_t addr,
                                 input acp_mem_pkg::burst_code_t code);
        int beats;
        int gap;
        beats = 1 << code;
        while (!cmd_ready[ch]) begin
            wait_cycles(1);
        end
        cmd_valid[ch] = 1'b1;
        cmd_we[ch] = we;
        cmd_addr[ch] = addr;
        cmd_burst[ch] = code;
        wait_cycles(1);
        cmd_valid[ch] = 1'b0;
        if (we) begin
            for (int i = 0; i < beats; i++) begin
                gap = $urandom_range(0, 2);
                wait_cycles(gap);
                wdata_valid[ch] = 1'b1;
                wdata[ch] = $urandom;
                wait_cycles(1);
                wdata_valid[ch] = 1'b0;
            end
        end
        while (!done[ch]) begin
            wait_cycles(1);
        end
    endtask

    task automatic drive_channel(input int ch);
        int gap;
        for (int a = 0; a < acp_mem_pkg::DEPTH; a += acp_mem_pkg::MAX_BURST) begin
            issue_command(ch, 1'b1, acp_mem_pkg::addr_t'(a), 2'd3);
        end
        // Eight-word bursts that run from 31 over to 0
        issue_command(ch, 1'b1, acp_mem_pkg::addr_t'(28 + 2 * ch), 2'd3);
        for (int a = 28; a < 32; a++) begin
            issue_command(ch, 1'b0, acp_mem_pkg::addr_t'(a), 2'd3);
        end
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            issue_command(ch, $urandom_range(0, 1), $urandom_range(0, 31), $urandom_range(0, 3));
            gap = $urandom_range(0, 3);
            wait_cycles(gap);
        end
    endtask

    initial begin
        int unsigned seed;
        int n_pass;
        int n_fail;
        seed = 32'hf2ac;
        void'($urandom(seed));
        clk = 1'b0;
        latency_counter_reset = 1'b1;
        for (int ch = 0; ch < 2; ch++) begin
            cmd_valid[ch] = 1'b0;
            cmd_we[ch] = 1'b0;
            cmd_addr[ch] = '0;
            cmd_burst[ch] = '0;
            wdata_valid[ch] = 1'b0;
            wdata[ch] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        latency_counter_reset = 1'b0;
        fork
            drive_channel(0);
            drive_channel(1);
        join
        wait_cycles(4);
        chk.report_tests(n_pass, n_fail);
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/acp_mem_pkg.sv
src/sample_ram.sv
src/bus_arbiter.sv
src/mem_interface.sv
src/burst_master.sv
src/acp_mem_subsystem.sv
bench/mem_checker.sv
bench/tb_acp_mem.sv

// File: src/acp_mem_pkg.sv
`default_nettype none

package acp_mem_pkg;

    // Bus and storage widths
    localparam int ADDR_W = 5;
    localparam int WORD_W = 32;
    localparam int DEPTH = 1 << ADDR_W;

    // Wait-state cycles between ack and the first data beat
    localparam int LATENCY = 4;
    localparam int LAT_W = $clog2(LATENCY) + 1;

    // Largest burst, also the write buffer depth
    localparam int MAX_BURST = 8;
    localparam int PTR_W = $clog2(MAX_BURST);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0] burst_code_t;
    typedef logic [3:0] beat_count_t;
    typedef logic [PTR_W-1:0] buf_ptr_t;

    // Burst code to word count: 1, 2, 4 or 8
    localparam beat_count_t BURST_BEATS [4] = '{4'd1, 4'd2, 4'd4, 4'd8};

    typedef enum logic [2:0] {
        wait_for_ack,
        read_wait,
        write_wait,
        read_data,
        write_data,
        finish
    } mem_state_t;

    typedef enum logic [2:0] {
        idle,
        loading,
        requesting,
        active,
        releasing
    } master_state_t;

endpackage

`default_nettype wire

// File: src/acp_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module acp_mem_subsystem (
    input  wire                           clk,
    input  wire                           latency_counter_reset,
    input  wire                           ch0_cmd_valid,
    output logic                          ch0_cmd_ready,
    input  wire                           ch0_cmd_we,
    input  wire acp_mem_pkg::addr_t       ch0_cmd_addr,
    input  wire acp_mem_pkg::burst_code_t ch0_cmd_burst,
    input  wire                           ch0_wdata_valid,
    input  wire acp_mem_pkg::word_t       ch0_wdata,
    output logic                          ch0_rdata_valid,
    output acp_mem_pkg::word_t            ch0_rdata,
    output logic                          ch0_done,
    input  wire                           ch1_cmd_valid,
    output logic                          ch1_cmd_ready,
    input  wire                           ch1_cmd_we,
    input  wire acp_mem_pkg::addr_t       ch1_cmd_addr,
    input  wire acp_mem_pkg::burst_code_t ch1_cmd_burst,
    input  wire                           ch1_wdata_valid,
    input  wire acp_mem_pkg::word_t       ch1_wdata,
    output logic                          ch1_rdata_valid,
    output acp_mem_pkg::word_t            ch1_rdata,
    output logic                          ch1_done
);

    // Channel requests toward the arbiter
    logic ch0_req;
    logic ch0_req_we;
    logic ch0_grant;
    acp_mem_pkg::addr_t ch0_req_addr;
    acp_mem_pkg::burst_code_t ch0_req_burst;
    acp_mem_pkg::word_t ch0_req_wdata;
    logic ch1_req;
    logic ch1_req_we;
    logic ch1_grant;
    acp_mem_pkg::addr_t ch1_req_addr;
    acp_mem_pkg::burst_code_t ch1_req_burst;
    acp_mem_pkg::word_t ch1_req_wdata;

    // Shared bus after the arbiter
    logic bus_ack;
    logic bus_we;
    acp_mem_pkg::addr_t bus_addr;
    acp_mem_pkg::burst_code_t bus_burst;
    acp_mem_pkg::word_t bus_wdata;

    // Interface and RAM side
    logic data_we;
    logic read_beat;
    logic burst_done;
    acp_mem_pkg::addr_t ram_addr;
    acp_mem_pkg::word_t ram_rdata;

    burst_master ch0 (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .cmd_valid(ch0_cmd_valid), .cmd_ready(ch0_cmd_ready),
        .cmd_we(ch0_cmd_we), .cmd_addr(ch0_cmd_addr), .cmd_burst(ch0_cmd_burst),
        .wdata_valid(ch0_wdata_valid), .wdata(ch0_wdata),
        .rdata_valid(ch0_rdata_valid), .rdata(ch0_rdata), .done(ch0_done),
        .grant(ch0_grant), .data_we(data_we), .read_beat(read_beat),
        .burst_done(burst_done), .bus_rdata(ram_rdata),
        .req(ch0_req), .req_we(ch0_req_we), .req_addr(ch0_req_addr),
        .req_burst(ch0_req_burst), .req_wdata(ch0_req_wdata)
    );

    burst_master ch1 (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .cmd_valid(ch1_cmd_valid), .cmd_ready(ch1_cmd_ready),
        .cmd_we(ch1_cmd_we), .cmd_addr(ch1_cmd_addr), .cmd_burst(ch1_cmd_burst),
        .wdata_valid(ch1_wdata_valid), .wdata(ch1_wdata),
        .rdata_valid(ch1_rdata_valid), .rdata(ch1_rdata), .done(ch1_done),
        .grant(ch1_grant), .data_we(data_we), .read_beat(read_beat),
        .burst_done(burst_done), .bus_rdata(ram_rdata),
        .req(ch1_req), .req_we(ch1_req_we), .req_addr(ch1_req_addr),
        .req_burst(ch1_req_burst), .req_wdata(ch1_req_wdata)
    );

    bus_arbiter arbiter (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .req0(ch0_req), .req1(ch1_req), .we0(ch0_req_we), .we1(ch1_req_we),
        .addr0(ch0_req_addr), .addr1(ch1_req_addr),
        .burst0(ch0_req_burst), .burst1(ch1_req_burst),
        .wdata0(ch0_req_wdata), .wdata1(ch1_req_wdata),
        .grant0(ch0_grant), .grant1(ch1_grant),
        .ack(bus_ack), .we(bus_we), .addr(bus_addr), .burst(bus_burst), .wdata(bus_wdata)
    );

    // No consumer of the wait flag in this subsystem
    mem_interface mem_if (
        .clk(clk), .latency_counter_reset(latency_counter_reset),
        .ack(bus_ack), .we(bus_we), .addr(bus_addr), .burst(bus_burst),
        .wait_out(), .data_we(data_we), .read_beat(read_beat),
        .burst_done(burst_done), .ram_addr(ram_addr)
    );

    sample_ram ram (
        .clk(clk), .addr(ram_addr), .we(data_we), .wdata(bus_wdata), .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// File: src/burst_master.sv
`timescale 1ns/1ps
`default_nettype none

module burst_master (
    input  wire                           clk,
    input  wire                           latency_counter_reset,
    input  wire                           cmd_valid,
    output logic                          cmd_ready,
    input  wire                           cmd_we,
    input  wire acp_mem_pkg::addr_t       cmd_addr,
    input  wire acp_mem_pkg::burst_code_t cmd_burst,
    input  wire                           wdata_valid,
    input  wire acp_mem_pkg::word_t       wdata,
    output logic                          rdata_valid,
    output acp_mem_pkg::word_t            rdata,
    output logic                          done,
    input  wire                           grant,
    input  wire                           data_we,
    input  wire                           read_beat,
    input  wire                           burst_done,
    input  wire acp_mem_pkg::word_t       bus_rdata,
    output logic                          req,
    output logic                          req_we,
    output acp_mem_pkg::addr_t            req_addr,
    output acp_mem_pkg::burst_code_t      req_burst,
    output acp_mem_pkg::word_t            req_wdata
);

    acp_mem_pkg::master_state_t state;

    logic cmd_we_q;
    acp_mem_pkg::addr_t cmd_addr_q;
    acp_mem_pkg::burst_code_t cmd_burst_q;

    acp_mem_pkg::word_t wbuf [acp_mem_pkg::MAX_BURST];
    acp_mem_pkg::buf_ptr_t load_ptr;
    acp_mem_pkg::buf_ptr_t rd_ptr;

    logic cmd_accept;
    logic load_word;
    logic last_load;

    assign cmd_accept = cmd_valid && cmd_ready;
    assign load_word = (state == acp_mem_pkg::loading) && wdata_valid;
    assign last_load = load_word && (acp_mem_pkg::beat_count_t'(load_ptr) + 4'd1 ==
        acp_mem_pkg::BURST_BEATS[cmd_burst_q]);

    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            state <= acp_mem_pkg::idle;
        end else begin
            case (state)
                acp_mem_pkg::idle: begin
                    if (cmd_valid && cmd_we) begin
                        state <= acp_mem_pkg::loading;
                    end else if (cmd_valid) begin
                        state <= acp_mem_pkg::requesting;
                    end
                end
                acp_mem_pkg::loading: begin
                    if (last_load) begin
                        state <= acp_mem_pkg::requesting;
                    end
                end
                acp_mem_pkg::requesting: begin
                    if (grant) begin
                        state <= acp_mem_pkg::active;
                    end
                end
                // burst_done is shared, so only ours counts
                acp_mem_pkg::active: begin
                    if (grant && burst_done) begin
                        state <= acp_mem_pkg::releasing;
                    end
                end
                default: begin
                    state <= acp_mem_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_we_q <= cmd_we;
            cmd_addr_q <= cmd_addr;
            cmd_burst_q <= cmd_burst;
        end
    end

    // Load pointer fills the buffer, read pointer follows the write beats
    always_ff @(posedge clk) begin
        if (latency_counter_reset || cmd_accept) begin
            load_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (load_word) begin
                load_ptr <= load_ptr + 1'b1;
            end
            if (grant && data_we) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_word) begin
            wbuf[load_ptr] <= wdata;
        end
    end

    // Read words go out one cycle after their beat
    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= grant && read_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (grant && read_beat) begin
            rdata <= bus_rdata;
        end
    end

    assign cmd_ready = (state == acp_mem_pkg::idle);
    assign done = (state == acp_mem_pkg::releasing);
    assign req = (state == acp_mem_pkg::requesting) || (state == acp_mem_pkg::active);
    assign req_we = cmd_we_q;
    assign req_addr = cmd_addr_q;
    assign req_burst = cmd_burst_q;
    assign req_wdata = wbuf[rd_ptr];

    assert property (@(posedge clk) disable iff (latency_counter_reset)
        wdata_valid |-> (state == acp_mem_pkg::loading))
        else $error("write word presented outside the load phase");

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                             clk,
    input  wire                             latency_counter_reset,
    input  wire                             req0,
    input  wire                             req1,
    input  wire                             we0,
    input  wire                             we1,
    input  wire acp_mem_pkg::addr_t         addr0,
    input  wire acp_mem_pkg::addr_t         addr1,
    input  wire acp_mem_pkg::burst_code_t   burst0,
    input  wire acp_mem_pkg::burst_code_t   burst1,
    input  wire acp_mem_pkg::word_t         wdata0,
    input  wire acp_mem_pkg::word_t         wdata1,
    output logic                            grant0,
    output logic                            grant1,
    output logic                            ack,
    output logic                            we,
    output acp_mem_pkg::addr_t              addr,
    output acp_mem_pkg::burst_code_t        burst,
    output acp_mem_pkg::word_t              wdata
);

    // Channel that won most recently
    logic last;
    logic held;
    logic pick1;

    // A grant stays as long as its owner keeps req high
    assign held = (grant0 && req0) || (grant1 && req1);

    // On a tie the channel that did not win last time goes first
    assign pick1 = req1 && (!req0 || !last);

    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            grant0 <= 1'b0;
            grant1 <= 1'b0;
            last <= 1'b1;
        end else if (!held) begin
            grant0 <= req0 && !pick1;
            grant1 <= pick1;
            if (req0 || req1) begin
                last <= pick1;
            end
        end
    end

    // Shared bus follows the granted channel
    assign ack = held;
    assign we = grant1 ? we1 : we0;
    assign addr = grant1 ? addr1 : addr0;
    assign burst = grant1 ? burst1 : burst0;
    assign wdata = grant1 ? wdata1 : wdata0;

    assert property (@(posedge clk) disable iff (latency_counter_reset)
        !(grant0 && grant1))
        else $error("both channels granted");

endmodule

`default_nettype wire

// File: src/mem_interface.sv
`timescale 1ns/1ps
`default_nettype none

module mem_interface (
    input  wire                           clk,
    input  wire                           latency_counter_reset,
    input  wire                           ack,
    input  wire                           we,
    input  wire acp_mem_pkg::addr_t       addr,
    input  wire acp_mem_pkg::burst_code_t burst,
    output logic                          wait_out,
    output logic                          data_we,
    output logic                          read_beat,
    output logic                          burst_done,
    output acp_mem_pkg::addr_t            ram_addr
);

    acp_mem_pkg::mem_state_t state;
    acp_mem_pkg::mem_state_t state_next;

    logic [acp_mem_pkg::LAT_W-1:0] lat_cnt;
    acp_mem_pkg::addr_t addr_cnt;
    acp_mem_pkg::beat_count_t beats;
    acp_mem_pkg::beat_count_t beat_cnt;

    logic in_wait;
    logic in_data;
    logic last_wait;
    logic last_beat;

    assign in_wait = (state == acp_mem_pkg::read_wait) || (state == acp_mem_pkg::write_wait);
    assign in_data = (state == acp_mem_pkg::read_data) || (state == acp_mem_pkg::write_data);
    assign last_wait = (lat_cnt == acp_mem_pkg::LATENCY - 1);

    // Counting beats keeps bursts that wrap past address 31 correct
    assign last_beat = (beat_cnt == beats - 4'd1);

    always_ff @(posedge clk) begin
        if (latency_counter_reset) begin
            state <= acp_mem_pkg::wait_for_ack;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            acp_mem_pkg::wait_for_ack: begin
                if (ack) begin
                    if (we) begin
                        state_next = acp_mem_pkg::write_wait;
                    end else begin
                        state_next = acp_mem_pkg::read_wait;
                    end
                end
            end
            acp_mem_pkg::read_wait: begin
                if (last_wait) begin
                    state_next = acp_mem_pkg::read_data;
                end
            end
            acp_mem_pkg::write_wait: begin
                if (last_wait) begin
                    state_next = acp_mem_pkg::write_data;
                end
            end
            acp_mem_pkg::read_data, acp_mem_pkg::write_data: begin
                if (last_beat) begin
                    state_next = acp_mem_pkg::finish;
                end
            end
            // Hold until the requester lets go of ack
            acp_mem_pkg::finish: begin
                if (!ack) begin
                    state_next = acp_mem_pkg::wait_for_ack;
                end
            end
            default: begin
                state_next = acp_mem_pkg::wait_for_ack;
            end
        endcase
    end

    // Latency and beat counters restart every time we sit idle
    always_ff @(posedge clk) begin
        if (latency_counter_reset || state == acp_mem_pkg::wait_for_ack) begin
            lat_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            if (in_wait) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
            if (in_data) begin
                beat_cnt <= beat_cnt + 4'd1;
            end
        end
    end

    // Start address and burst length captured while idle
    always_ff @(posedge clk) begin
        if (state == acp_mem_pkg::wait_for_ack) begin
            addr_cnt <= addr;
            beats <= acp_mem_pkg::BURST_BEATS[burst];
        end else if (in_data) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // Wait drops in the last latency cycle
    assign wait_out = in_wait && !last_wait;
    assign data_we = (state == acp_mem_pkg::write_data);
    assign read_beat = (state == acp_mem_pkg::read_data);
    assign burst_done = (state == acp_mem_pkg::finish);
    assign ram_addr = addr_cnt;

    assert property (@(posedge clk) disable iff (latency_counter_reset)
        (state == acp_mem_pkg::wait_for_ack && ack) |=> (ack until_with burst_done))
        else $error("ack dropped before burst_done");

    assert property (@(posedge clk) disable iff (latency_counter_reset)
        !(data_we && read_beat))
        else $error("write and read beat in the same cycle");

endmodule

`default_nettype wire

// File: src/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  wire                     clk,
    input  wire acp_mem_pkg::addr_t addr,
    input  wire                     we,
    input  wire acp_mem_pkg::word_t wdata,
    output acp_mem_pkg::word_t      rdata
);

    // Sample storage, undefined until written
    acp_mem_pkg::word_t mem [acp_mem_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Asynchronous read, so a read beat's word is ready in its own cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire
